//--- design/aes_cipher_core.sv
// AES-256 iterative encryption core
module aes_cipher_core
(
   input  logic                m_axi_mm2s_aclk,
   input  logic                rst_n_i,
   input  aes_pkg::key_t       key_i,
   input  aes_pkg::data_beat_t in_beat_i,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   input  logic                stall_i,
   output aes_pkg::data_beat_t res_beat_o,
   output logic                res_valid_o
);
   import aes_pkg::*;

   localparam logic [3:0] LAST_ROUND = 4'd14;

   core_state_e state_q;
   core_state_e state_d;
   logic        idle_q;        // Registered idle decode, low out of reset
   logic [3:0]  rnd_q;
   block_t      blk_q;
   logic        last_q;
   block_t      rk_a_q;        // Older half of the key window
   block_t      rk_b_q;        // Round key in use
   logic [7:0]  sb [16];
   block_t      sr_blk;
   block_t      mc_blk;
   block_t      rnd_out;
   word_t       kw_sub;
   word_t       kw_t;
   logic [7:0]  rcon;
   block_t      rk_next;
   logic        accept;

   function automatic logic [7:0] xtime(input logic [7:0] b);
      xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
   endfunction

   function automatic word_t mix_col(input word_t col);
      logic [7:0] a0;
      logic [7:0] a1;
      logic [7:0] a2;
      logic [7:0] a3;
      a0 = col[31:24];
      a1 = col[23:16];
      a2 = col[15:8];
      a3 = col[7:0];
      mix_col = {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                 a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                 a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                 xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
   endfunction

   assign in_ready_o = idle_q & ~stall_i;
   assign accept     = in_valid_i & in_ready_o;

   // SubBytes on the state
   for (genvar i = 0; i < 16; i++)
   begin : g_state_sbox
      aes_sbox u_sbox (.in_i(blk_q[127 - 8*i -: 8]), .out_o(sb[i]));
   end

   // SubWord on the last word of the key window
   for (genvar j = 0; j < 4; j++)
   begin : g_key_sbox
      aes_sbox u_sbox (.in_i(rk_b_q[31 - 8*j -: 8]), .out_o(kw_sub[31 - 8*j -: 8]));
   end

   always_comb
   begin
      // ShiftRows, row r of column c comes from column c + r
      for (int c = 0; c < 4; c++)
         for (int r = 0; r < 4; r++)
            sr_blk[127 - 8*(4*c + r) -: 8] = sb[4*((c + r) % 4) + r];
      for (int c = 0; c < 4; c++)
         mc_blk[127 - 32*c -: 32] = mix_col(sr_blk[127 - 32*c -: 32]);
      rnd_out = ((rnd_q == LAST_ROUND) ? sr_blk : mc_blk) ^ rk_b_q;
   end

   assign rcon = 8'h01 << rnd_q[3:1];

   // Next four schedule words, RotWord and Rcon on every other step
   always_comb
   begin
      if (rnd_q[0])
         kw_t = {kw_sub[23:0], kw_sub[31:24]} ^ {rcon, 24'h0};
      else
         kw_t = kw_sub;
      rk_next[127:96] = rk_a_q[127:96] ^ kw_t;
      rk_next[95:64]  = rk_a_q[95:64] ^ rk_next[127:96];
      rk_next[63:32]  = rk_a_q[63:32] ^ rk_next[95:64];
      rk_next[31:0]   = rk_a_q[31:0] ^ rk_next[63:32];
   end

   always_comb
   begin
      state_d = state_q;
      unique case (state_q)
         IDLE:
            if (accept)
               state_d = ROUND;
         ROUND:
            if (rnd_q == LAST_ROUND)
               state_d = DONE;
         DONE:
            state_d = IDLE;   // FIFO takes the result this cycle
         default:
            state_d = IDLE;
      endcase
   end

   always_ff @(posedge m_axi_mm2s_aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q <= IDLE;
         idle_q  <= 1'b0;
         rnd_q   <= '0;
      end
      else
      begin
         state_q <= state_d;
         idle_q  <= (state_d == IDLE);
         if (accept)
            rnd_q <= 4'd1;
         else if (state_q == ROUND)
            rnd_q <= rnd_q + 4'd1;
      end
   end

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (accept)
      begin
         blk_q  <= in_beat_i.block ^ key_i[255:128];   // Round 0 key
         last_q <= in_beat_i.last;
         rk_a_q <= key_i[255:128];
         rk_b_q <= key_i[127:0];
      end
      else if (state_q == ROUND)
      begin
         blk_q  <= rnd_out;
         rk_a_q <= rk_b_q;
         rk_b_q <= rk_next;
      end
   end

   assign res_beat_o  = '{block: blk_q, last: last_q};
   assign res_valid_o = (state_q == DONE);

endmodule

//--- design/aes_pkg.sv
// AES stream engine shared definitions
package aes_pkg;

   localparam int BLOCK_W    = 128;
   localparam int KEY_W      = 256;
   localparam int WORD_W     = 32;
   localparam int APB_ADDR_W = 8;
   localparam int KEY_WORDS  = KEY_W / WORD_W;

   typedef logic [BLOCK_W-1:0]    block_t;     // FIPS-197 byte 0 at the top
   typedef logic [KEY_W-1:0]      key_t;       // Key word 0 at the top
   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [31:0]           blk_cnt_t;

   typedef struct packed {
      block_t block;
      logic   last;
   } data_beat_t;

   typedef struct packed {
      word_t data;
      logic  last;
   } sts_beat_t;

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      word_t     pwdata;
   } apb_req_t;

   typedef struct packed {
      word_t prdata;
      logic  pready;
      logic  pslverr;
   } apb_rsp_t;

   // Register map
   localparam apb_addr_t KEY_BASE_ADDR = 8'h00;   // Eight key words, 4 bytes apart
   localparam apb_addr_t BLK_CNT_ADDR  = 8'h20;   // Read only

   localparam word_t STS_HEAD_WORD = 32'h5000_0000;
   localparam int    STS_LEN       = 5;

   typedef enum logic [1:0] {
      IDLE,
      ROUND,
      DONE
   } core_state_e;

endpackage

//--- design/aes_sbox.sv
// AES forward S-box
module aes_sbox
(
   input  logic [7:0] in_i,
   output logic [7:0] out_o
);

   // Entry 0 sits in the top byte of the first row
   localparam logic [0:255][7:0] SBOX = {
      128'h637c777bf26b6fc53001672bfed7ab76,
      128'hca82c97dfa5947f0add4a2af9ca472c0,
      128'hb7fd9326363ff7cc34a5e5f171d83115,
      128'h04c723c31896059a071280e2eb27b275,
      128'h09832c1a1b6e5aa0523bd6b329e32f84,
      128'h53d100ed20fcb15b6acbbe394a4c58cf,
      128'hd0efaafb434d338545f9027f503c9fa8,
      128'h51a3408f929d38f5bcb6da2110fff3d2,
      128'hcd0c13ec5f974417c4a77e3d645d1973,
      128'h60814fdc222a908846eeb814de5e0bdb,
      128'he0323a0a4906245cc2d3ac629195e479,
      128'he7c8376d8dd54ea96c56f4ea657aae08,
      128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
      128'h703eb5664803f60e613557b986c11d9e,
      128'he1f8981169d98e949b1e87e9ce5528df,
      128'h8ca1890dbfe6426841992d0fb054bb16
   };

   assign out_o = SBOX[in_i];

endmodule

//--- design/aes_stream_engine.sv
// Streaming AES-256 encryption engine
module aes_stream_engine
#(
   parameter int DATA_FIFO_DEPTH = 16,
   parameter int STS_FIFO_DEPTH  = 8
)
(
   input  logic                m_axi_mm2s_aclk,
   input  logic                rst_n_i,
   input  aes_pkg::apb_req_t   apb_req_i,
   output aes_pkg::apb_rsp_t   apb_rsp_o,
   input  aes_pkg::data_beat_t in_beat_i,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   output aes_pkg::data_beat_t out_beat_o,
   output logic                out_valid_o,
   input  logic                out_ready_i,
   output aes_pkg::sts_beat_t  sts_beat_o,
   output logic                sts_valid_o,
   input  logic                sts_ready_i
);
   import aes_pkg::*;

   localparam int STS_FREE_W = $clog2(STS_FIFO_DEPTH + 1);

   key_t                  key;
   data_beat_t            res_beat;
   logic                  res_valid;
   logic                  data_afull;
   logic                  data_valid;     // FIFO head present
   logic                  last_held;
   logic                  out_ready_gated;
   logic                  out_xfer;
   logic                  sts_hold;
   sts_beat_t             sts_wr_beat;
   logic                  sts_wr_valid;
   logic [STS_FREE_W-1:0] sts_free;

   // A last beat waits until the status FIFO can take a whole packet
   assign last_held       = out_beat_o.last & sts_hold;
   assign out_valid_o     = data_valid & ~last_held;
   assign out_ready_gated = out_ready_i & ~last_held;
   assign out_xfer        = out_valid_o & out_ready_i;

   apb_key_regs u_apb_key_regs (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .apb_req_i       (apb_req_i),
      .apb_rsp_o       (apb_rsp_o),
      .blk_done_i      (out_xfer),
      .key_o           (key)
   );

   aes_cipher_core u_aes_cipher_core (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .key_i           (key),
      .in_beat_i       (in_beat_i),
      .in_valid_i      (in_valid_i),
      .in_ready_o      (in_ready_o),
      .stall_i         (data_afull),
      .res_beat_o      (res_beat),
      .res_valid_o     (res_valid)
   );

   stream_fifo #(
      .WIDTH        ($bits(data_beat_t)),
      .DEPTH        (DATA_FIFO_DEPTH),
      .AFULL_MARGIN (1)
   ) u_data_fifo (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .wr_data_i       (res_beat),
      .wr_valid_i      (res_valid),
      .afull_o         (data_afull),
      .free_o          (),
      .rd_data_o       (out_beat_o),
      .rd_valid_o      (data_valid),
      .rd_ready_i      (out_ready_gated)
   );

   frame_status_gen #(
      .FREE_W (STS_FREE_W)
   ) u_frame_status_gen (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .frame_end_i     (out_xfer & out_beat_o.last),
      .sts_free_i      (sts_free),
      .hold_o          (sts_hold),
      .sts_beat_o      (sts_wr_beat),
      .sts_valid_o     (sts_wr_valid)
   );

   stream_fifo #(
      .WIDTH        ($bits(sts_beat_t)),
      .DEPTH        (STS_FIFO_DEPTH),
      .AFULL_MARGIN (1)
   ) u_sts_fifo (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .wr_data_i       (sts_wr_beat),
      .wr_valid_i      (sts_wr_valid),
      .afull_o         (),
      .free_o          (sts_free),
      .rd_data_o       (sts_beat_o),
      .rd_valid_o      (sts_valid_o),
      .rd_ready_i      (sts_ready_i)
   );

endmodule

//--- design/apb_key_regs.sv
// APB key and block counter registers
module apb_key_regs
(
   input  logic              m_axi_mm2s_aclk,
   input  logic              rst_n_i,
   input  aes_pkg::apb_req_t apb_req_i,
   output aes_pkg::apb_rsp_t apb_rsp_o,
   input  logic              blk_done_i,
   output aes_pkg::key_t     key_o
);
   import aes_pkg::*;

   word_t      key_q [KEY_WORDS];
   blk_cnt_t   blk_cnt_q;
   logic       wr_req;
   logic       key_hit;
   apb_addr_t  key_off;
   logic [2:0] key_idx;

   assign wr_req  = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
   assign key_hit = (apb_req_i.paddr < BLK_CNT_ADDR);
   assign key_off = apb_req_i.paddr - KEY_BASE_ADDR;
   assign key_idx = key_off[4:2];   // One word every 4 bytes

   always_ff @(posedge m_axi_mm2s_aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         for (int i = 0; i < KEY_WORDS; i++)
            key_q[i] <= '0;
      end
      else if (wr_req && key_hit)
         key_q[key_idx] <= apb_req_i.pwdata;
   end

   always_ff @(posedge m_axi_mm2s_aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         blk_cnt_q <= '0;
      else if (blk_done_i)
         blk_cnt_q <= blk_cnt_q + 1'b1;
   end

   always_comb
   begin
      apb_rsp_o.pready  = 1'b1;   // No wait states
      apb_rsp_o.pslverr = wr_req & ~key_hit;
      if (key_hit)
         apb_rsp_o.prdata = key_q[key_idx];
      else if (apb_req_i.paddr == BLK_CNT_ADDR)
         apb_rsp_o.prdata = blk_cnt_q;
      else
         apb_rsp_o.prdata = '0;
   end

   // Word 0 ends up in the top bits
   always_comb
   begin
      for (int i = 0; i < KEY_WORDS; i++)
         key_o[KEY_W - 1 - WORD_W*i -: WORD_W] = key_q[i];
   end

endmodule

//--- design/frame_status_gen.sv
// Frame status packet generator
module frame_status_gen
#(
   parameter int FREE_W = 4
)
(
   input  logic               m_axi_mm2s_aclk,
   input  logic               rst_n_i,
   input  logic               frame_end_i,
   input  logic [FREE_W-1:0]  sts_free_i,
   output logic               hold_o,
   output aes_pkg::sts_beat_t sts_beat_o,
   output logic               sts_valid_o
);
   import aes_pkg::*;

   localparam int CNT_W = $clog2(STS_LEN + 1);

   logic [CNT_W-1:0] cnt_q;   // Words left in the packet

   always_ff @(posedge m_axi_mm2s_aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         cnt_q <= '0;
      else if (frame_end_i)
         cnt_q <= CNT_W'(STS_LEN);
      else if (cnt_q != '0)
         cnt_q <= cnt_q - 1'b1;
   end

   assign sts_valid_o     = (cnt_q != '0);
   assign sts_beat_o.data = (cnt_q == CNT_W'(STS_LEN)) ? STS_HEAD_WORD : '0;
   assign sts_beat_o.last = (cnt_q == CNT_W'(1));

   // Burst never stalls, so the next frame end waits for a full packet of room
   assign hold_o = (cnt_q != '0) | (sts_free_i < FREE_W'(STS_LEN));

endmodule

//--- design/stream_fifo.sv
// Register array FIFO with valid/ready ports
module stream_fifo
#(
   parameter int WIDTH        = 8,
   parameter int DEPTH        = 16,
   parameter int AFULL_MARGIN = 1
)
(
   input  logic                         m_axi_mm2s_aclk,
   input  logic                         rst_n_i,
   input  logic [WIDTH-1:0]             wr_data_i,
   input  logic                         wr_valid_i,
   output logic                         afull_o,
   output logic [$clog2(DEPTH + 1)-1:0] free_o,
   output logic [WIDTH-1:0]             rd_data_o,
   output logic                         rd_valid_o,
   input  logic                         rd_ready_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             rd_en;

   assign rd_valid_o = (count_q != '0);
   assign rd_data_o  = mem[rd_ptr_q];
   assign rd_en      = rd_valid_o & rd_ready_i;
   assign free_o     = CNT_W'(DEPTH) - count_q;
   assign afull_o    = (free_o <= CNT_W'(AFULL_MARGIN));

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (wr_valid_i)
         mem[wr_ptr_q] <= wr_data_i;
   end

   // Explicit wrap so non power of two depths work
   always_ff @(posedge m_axi_mm2s_aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (wr_valid_i)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (rd_en)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         case ({wr_valid_i, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;   // Both or neither
         endcase
      end
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AES stream engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_aes_stream_engine \
   -f sim.f -o sim_aes_stream_engine

./obj_dir/sim_aes_stream_engine

//--- sim.f
design/aes_pkg.sv
design/aes_sbox.sv
design/aes_cipher_core.sv
design/stream_fifo.sv
design/frame_status_gen.sv
design/apb_key_regs.sv
design/aes_stream_engine.sv
tests/aes_stream_checker.sv
tests/tb_aes_stream_engine.sv

//--- tests/aes_stream_checker.sv
// Stream and APB handshake checks
module aes_stream_checker
(
   input logic                m_axi_mm2s_aclk,
   input logic                rst_n_i,
   input aes_pkg::apb_req_t   apb_req_i,
   input aes_pkg::apb_rsp_t   apb_rsp_i,
   input aes_pkg::data_beat_t in_beat_i,
   input logic                in_valid_i,
   input logic                in_ready_i,
   input aes_pkg::data_beat_t out_beat_i,
   input logic                out_valid_i,
   input logic                out_ready_i,
   input aes_pkg::sts_beat_t  sts_beat_i,
   input logic                sts_valid_i,
   input logic                sts_ready_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // A pending beat keeps valid and data until it transfers
   in_hold_a: assert property (@(posedge m_axi_mm2s_aclk) disable iff (!rst_n_i)
      in_valid_i && !in_ready_i |=> in_valid_i && $stable(in_beat_i))
      else $error("Input stream beat dropped or changed before its transfer");

   out_hold_a: assert property (@(posedge m_axi_mm2s_aclk) disable iff (!rst_n_i)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_beat_i))
      else $error("Output stream beat dropped or changed before its transfer");

   sts_hold_a: assert property (@(posedge m_axi_mm2s_aclk) disable iff (!rst_n_i)
      sts_valid_i && !sts_ready_i |=> sts_valid_i && $stable(sts_beat_i))
      else $error("Status stream beat dropped or changed before its transfer");

   // No wait states on APB
   apb_ready_a: assert property (@(posedge m_axi_mm2s_aclk) disable iff (!rst_n_i)
      apb_req_i.psel && apb_req_i.penable |-> apb_rsp_i.pready)
      else $error("APB access phase without pready");

   reset_ready_a: assert property (@(posedge m_axi_mm2s_aclk)
      !rst_n_i |-> !in_ready_i)
      else $error("Input ready high while in reset");

endmodule

bind aes_stream_engine aes_stream_checker u_aes_stream_checker (
   .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
   .rst_n_i         (rst_n_i),
   .apb_req_i       (apb_req_i),
   .apb_rsp_i       (apb_rsp_o),
   .in_beat_i       (in_beat_i),
   .in_valid_i      (in_valid_i),
   .in_ready_i      (in_ready_o),
   .out_beat_i      (out_beat_o),
   .out_valid_i     (out_valid_o),
   .out_ready_i     (out_ready_i),
   .sts_beat_i      (sts_beat_o),
   .sts_valid_i     (sts_valid_o),
   .sts_ready_i     (sts_ready_i)
);

//--- tests/aes_testdata.txt
# K: key words 0 to 7 | P: last flag, plaintext, expected ciphertext
# R: APB address, expected read data | E: APB address, write data, pslverr expected
P 1 00000000000000000000000000000000 dc95c078a2408989ad48a21492842087
R 20 00000001
K 00010203 04050607 08090a0b 0c0d0e0f 10111213 14151617 18191a1b 1c1d1e1f
P 1 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
R 1c 1c1d1e1f
K 603deb10 15ca71be 2b73aef0 857d7781 1f352c07 3b6108d7 2d9810a3 0914dff4
P 0 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
P 0 ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870
P 1 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d
P 1 f69f2445df4f9b17ad2b417be66c3710 23304b7a39f9f3ff067d8d8f9e24ecc7
P 0 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
P 0 ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870
P 0 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d
P 1 f69f2445df4f9b17ad2b417be66c3710 23304b7a39f9f3ff067d8d8f9e24ecc7
P 1 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
P 1 ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870
P 1 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d
R 00 603deb10
R 14 3b6108d7
R 20 0000000d
E 20 12345678
E 24 ffffffff
E fc 00000000
R 20 0000000d
R 08 2b73aef0

//--- tests/tb_aes_stream_engine.sv
// AES stream engine testbench
module tb_aes_stream_engine;
   timeunit 1ns;
   timeprecision 100ps;
   import aes_pkg::*;

   localparam int    CLK_PERIOD = 20;
   localparam int    RST_CYCLES = 5;
   localparam int    SEED       = 32'h2f57_b3c1;
   localparam string DATA_FILE  = "tests/aes_testdata.txt";

   logic        m_axi_mm2s_aclk;
   logic        rst_n_i;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   data_beat_t  in_beat;
   logic        in_valid;
   logic        in_ready;
   data_beat_t  out_beat;
   logic        out_valid;
   logic        out_ready;
   sts_beat_t   sts_beat;
   logic        sts_valid;
   logic        sts_ready;

   logic [7:0]  cmd_q [$];      // Command letters in file order
   word_t       key_word_q [$];
   data_beat_t  plain_q [$];
   data_beat_t  cipher_q [$];
   apb_addr_t   addr_q [$];
   word_t       value_q [$];
   data_beat_t  send_q [$];
   data_beat_t  expect_q [$];
   int          cycle_cnt = 0;
   int          cycle_limit = 0;

   aes_stream_engine #(
      .DATA_FIFO_DEPTH (16),
      .STS_FIFO_DEPTH  (8)
   ) u_aes_stream_engine (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .apb_req_i       (apb_req),
      .apb_rsp_o       (apb_rsp),
      .in_beat_i       (in_beat),
      .in_valid_i      (in_valid),
      .in_ready_o      (in_ready),
      .out_beat_o      (out_beat),
      .out_valid_o     (out_valid),
      .out_ready_i     (out_ready),
      .sts_beat_o      (sts_beat),
      .sts_valid_o     (sts_valid),
      .sts_ready_i     (sts_ready)
   );

   initial
   begin
      m_axi_mm2s_aclk = 1'b0;
      forever #(CLK_PERIOD / 2) m_axi_mm2s_aclk = ~m_axi_mm2s_aclk;
   end

   always @(posedge m_axi_mm2s_aclk)
   begin
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit)
         stop_run($sformatf("Timeout, run not finished within %0d cycles", cycle_limit));
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic compare_block(input string name, input block_t got, input block_t exp);
      if (got !== exp)
         stop_run($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
                            $time, name, got, exp));
   endtask

   task automatic compare_status(input string name, input sts_beat_t got,
                                 input sts_beat_t exp);
      if (got !== exp)
         stop_run($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
                            $time, name, got, exp));
   endtask

   task automatic compare_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
         stop_run($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
                            $time, name, got, exp));
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_run($sformatf("MISMATCH at %0d ns: %s got %b expected %b",
                            $time, name, got, exp));
   endtask

   task automatic load_testdata();
      int         fd;
      int         n;
      int         need;
      string      line;
      logic [7:0] cmd;
      word_t      kw [KEY_WORDS];
      logic       last;
      block_t     pt;
      block_t     ct;
      apb_addr_t  addr;
      word_t      value;
      fd = $fopen(DATA_FILE, "r");
      if (fd == 0)
         stop_run("Cannot open the test data file");
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line[0] == "#")
            continue;
         case (line[0])
            "K":
            begin
               need = 9;
               n = $sscanf(line, "%c %h %h %h %h %h %h %h %h", cmd,
                           kw[0], kw[1], kw[2], kw[3], kw[4], kw[5], kw[6], kw[7]);
               foreach (kw[i])
                  key_word_q.push_back(kw[i]);
            end
            "P":
            begin
               need = 4;
               n = $sscanf(line, "%c %h %h %h", cmd, last, pt, ct);
               plain_q.push_back('{block: pt, last: last});
               cipher_q.push_back('{block: ct, last: last});
            end
            "R", "E":
            begin
               need = 3;
               n = $sscanf(line, "%c %h %h", cmd, addr, value);
               addr_q.push_back(addr);
               value_q.push_back(value);
            end
            default:
               stop_run($sformatf("Unknown command in test data: %s", line));
         endcase
         if (n != need)
            stop_run($sformatf("Malformed test data line: %s", line));
         cmd_q.push_back(cmd);
      end
      $fclose(fd);
   endtask

   // One APB transfer with a setup and an access phase and no wait states
   task automatic apb_access(input logic write, input apb_addr_t addr, input word_t wdata,
                             output word_t rdata, output logic err);
      @(negedge m_axi_mm2s_aclk);
      apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
      @(negedge m_axi_mm2s_aclk);
      apb_req.penable = 1'b1;
      #(CLK_PERIOD / 4);   // Mid access phase ahead of the update edge
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(negedge m_axi_mm2s_aclk);
      apb_req = '0;
   endtask

   task automatic send_blocks();
      while (send_q.size() > 0)
      begin
         @(negedge m_axi_mm2s_aclk);
         in_beat  = send_q[0];
         in_valid = 1'b1;
         if (in_ready)   // Ready comes from registers and holds to the next rising edge
            void'(send_q.pop_front());
      end
      @(negedge m_axi_mm2s_aclk);
      in_valid = 1'b0;
   endtask

   task automatic collect_blocks(input int count);
      data_beat_t exp;
      int         got;
      got = 0;
      while (got < count)
      begin
         @(negedge m_axi_mm2s_aclk);
         out_ready = (($urandom % 4) != 0);
         if (out_valid && out_ready)
         begin
            exp = expect_q.pop_front();
            compare_block("out_beat_o.block", out_beat.block, exp.block);
            compare_flag("out_beat_o.last", out_beat.last, exp.last);
            got++;
         end
      end
      @(negedge m_axi_mm2s_aclk);
      out_ready = 1'b0;
   endtask

   task automatic collect_status(input int count);
      sts_beat_t exp;
      int        got;
      got = 0;
      while (got < count)
      begin
         @(negedge m_axi_mm2s_aclk);
         sts_ready = (($urandom % 2) != 0);
         if (sts_valid && sts_ready)
         begin
            exp.data = (got % STS_LEN == 0) ? STS_HEAD_WORD : '0;   // Header, then zeros
            exp.last = (got % STS_LEN == STS_LEN - 1);
            compare_status("sts_beat_o", sts_beat, exp);
            got++;
         end
      end
      @(negedge m_axi_mm2s_aclk);
      sts_ready = 1'b0;
   endtask

   task automatic run_pending();
      int frames;
      int blocks;
      frames = 0;
      blocks = send_q.size();
      foreach (expect_q[i])
         if (expect_q[i].last)
            frames++;
      if (blocks > 0)
         fork
            send_blocks();
            collect_blocks(blocks);
            collect_status(frames * STS_LEN);
         join
   endtask

   initial
   begin
      word_t rdata;
      logic  err;
      apb_req   = '0;
      in_beat   = '0;
      in_valid  = 1'b0;
      out_ready = 1'b0;
      sts_ready = 1'b0;
      rst_n_i   = 1'b0;
      void'($urandom(SEED));
      load_testdata();
      cycle_limit = plain_q.size() * 40 + 500;
      repeat (RST_CYCLES) @(negedge m_axi_mm2s_aclk);
      rst_n_i = 1'b1;
      foreach (cmd_q[i])
      begin
         if (cmd_q[i] == "P")
         begin
            send_q.push_back(plain_q.pop_front());
            expect_q.push_back(cipher_q.pop_front());
         end
         else
         begin
            run_pending();   // Frames so far finish before any register access
            case (cmd_q[i])
               "K":
                  for (int w = 0; w < KEY_WORDS; w++)
                  begin
                     apb_access(1'b1, KEY_BASE_ADDR + apb_addr_t'(4 * w),
                                key_word_q.pop_front(), rdata, err);
                     compare_flag("apb_rsp_o.pslverr", err, 1'b0);
                  end
               "R":
               begin
                  apb_access(1'b0, addr_q.pop_front(), '0, rdata, err);
                  compare_word("apb_rsp_o.prdata", rdata, value_q.pop_front());
                  compare_flag("apb_rsp_o.pslverr", err, 1'b0);
               end
               default:
               begin
                  apb_access(1'b1, addr_q.pop_front(), value_q.pop_front(), rdata, err);
                  compare_flag("apb_rsp_o.pslverr", err, 1'b1);
               end
            endcase
         end
      end
      run_pending();
      repeat (20) @(negedge m_axi_mm2s_aclk);   // Longer than one block time
      if (out_valid || sts_valid)
         stop_run("Output or status beat left over after all expected beats");
      else
      begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule
